/* rtl/unwrap_pkg.sv */
// Shared AXI read field types, burst encodings and queue depth for the read burst unwrapper
`default_nettype none

package unwrap_pkg;

  // ----------------------------------------
  // AXI read channel fields
  // ----------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;
  typedef logic [3:0]  id_t;
  typedef logic [31:0] data_t;

  // Burst type encodings, as on the bus
  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR  = 2'd1;
  localparam burst_t BURST_WRAP  = 2'd2;

  // ----------------------------------------
  // Beat counter queue
  // ----------------------------------------
  // Reads that may be outstanding at once
  localparam int unsigned MAX_READ_TXNS = 4;

  // Remaining beats of one burst, up to 256 so one bit wider than len_t
  typedef logic [$bits(len_t):0] cnt_t;

  // Slot index into the counter queue
  typedef logic [$clog2(MAX_READ_TXNS)-1:0] cnt_idx_t;

endpackage

`default_nettype wire

/* rtl/ar_splitter.sv */
// AR channel stage that turns unaligned wrap bursts into two INCR bursts; used by the top level
`timescale 1ns/10ps
`default_nettype none

module ar_splitter (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  // Upstream AR
  input  wire logic              ar_valid_i,
  input  wire unwrap_pkg::addr_t  ar_addr_i,
  input  wire unwrap_pkg::len_t   ar_len_i,
  input  wire unwrap_pkg::size_t  ar_size_i,
  input  wire unwrap_pkg::burst_t ar_burst_i,
  input  wire unwrap_pkg::id_t    ar_id_i,
  output logic                   ar_ready_o,
  // Downstream AR
  output logic                   out_valid_o,
  output unwrap_pkg::addr_t      out_addr_o,
  output unwrap_pkg::len_t       out_len_o,
  output unwrap_pkg::size_t      out_size_o,
  output unwrap_pkg::burst_t     out_burst_o,
  output unwrap_pkg::id_t        out_id_o,
  input  wire logic              out_ready_i,
  // Counter allocation
  output logic                   alloc_req_o,
  output unwrap_pkg::len_t       alloc_len_o,
  input  wire logic              alloc_gnt_i
);
  import unwrap_pkg::*;

  typedef enum logic {
    AR_IDLE,
    AR_BUSY
  } ar_state_e;

  ar_state_e state_q, state_d;

  addr_t container_size;
  addr_t wrap_boundary;
  logic  need_split;
  len_t  first_len;
  len_t  second_len;
  logic  load_second;

  // Second piece of a split, sent from the busy state
  addr_t sec_addr_q;
  len_t  sec_len_q;
  size_t sec_size_q;
  id_t   sec_id_q;

  // ----------------------------------------
  // Wrap geometry
  // ----------------------------------------
  // Bytes covered by the whole burst, a power of two for legal wrap bursts
  assign container_size = (addr_t'(ar_len_i) + addr_t'(1)) << ar_size_i;
  assign wrap_boundary  = ar_addr_i & ~(container_size - addr_t'(1));
  assign need_split     = (ar_burst_i == BURST_WRAP) && (ar_addr_i != wrap_boundary);

  // From the start address up to the end of the container
  assign first_len  = len_t'(((wrap_boundary + container_size - ar_addr_i) >> ar_size_i)
                             - addr_t'(1));
  // From the boundary back up to the start address
  assign second_len = len_t'(((ar_addr_i - wrap_boundary) >> ar_size_i) - addr_t'(1));

  // ----------------------------------------
  // State machine
  // ----------------------------------------
  always_comb begin
    state_d     = state_q;
    ar_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    out_addr_o  = ar_addr_i;
    out_len_o   = ar_len_i;
    out_size_o  = ar_size_i;
    out_burst_o = ar_burst_i;
    out_id_o    = ar_id_i;
    alloc_req_o = 1'b0;
    // Upstream sees one burst, so the counter always gets the full length
    alloc_len_o = ar_len_i;
    load_second = 1'b0;

    unique case (state_q)
      AR_IDLE: begin
        // Hold off until a counter slot is free
        if (ar_valid_i && alloc_gnt_i) begin
          out_valid_o = 1'b1;
          if (need_split) begin
            out_burst_o = BURST_INCR;
            out_len_o   = first_len;
            if (out_ready_i) begin
              ar_ready_o  = 1'b1;
              alloc_req_o = 1'b1;
              load_second = 1'b1;
              state_d     = AR_BUSY;
            end
          end else begin
            // Aligned wrap maps directly onto an INCR burst
            if (ar_burst_i == BURST_WRAP) begin
              out_burst_o = BURST_INCR;
            end
            if (out_ready_i) begin
              ar_ready_o  = 1'b1;
              alloc_req_o = 1'b1;
            end
          end
        end
      end
      AR_BUSY: begin
        out_valid_o = 1'b1;
        out_addr_o  = sec_addr_q;
        out_len_o   = sec_len_q;
        out_size_o  = sec_size_q;
        out_burst_o = BURST_INCR;
        out_id_o    = sec_id_q;
        if (out_ready_i) begin
          state_d = AR_IDLE;
        end
      end
      default: begin
        state_d = AR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= AR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_second) begin
      sec_addr_q <= wrap_boundary;
      sec_len_q  <= second_len;
      sec_size_q <= ar_size_i;
      sec_id_q   <= ar_id_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/beat_count_queue.sv */
// In-order queue of remaining-beat counters that tells the R stage where each upstream burst ends
`timescale 1ns/10ps
`default_nettype none

module beat_count_queue (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  // Allocate, one entry per accepted upstream AR
  input  wire logic            alloc_req_i,
  input  wire unwrap_pkg::len_t alloc_len_i,
  output logic                 alloc_gnt_o,
  // Count down, one per R beat
  input  wire logic            cnt_req_i,
  input  wire logic            cnt_dec_i,
  output logic                 cnt_gnt_o,
  output unwrap_pkg::len_t     cnt_len_o
);
  import unwrap_pkg::*;

  // Occupancy needs to hold the full depth
  typedef logic [$clog2(MAX_READ_TXNS + 1)-1:0] occ_t;

  cnt_t     cnt_q [MAX_READ_TXNS];
  cnt_idx_t wr_idx_q;
  cnt_idx_t rd_idx_q;
  occ_t     count_q;

  cnt_t head_cnt;
  cnt_t head_left;
  logic do_alloc;
  logic do_dec;
  logic do_pop;

  // ----------------------------------------
  // Handshakes
  // ----------------------------------------
  assign alloc_gnt_o = (count_q != occ_t'(MAX_READ_TXNS));
  assign cnt_gnt_o   = (count_q != '0);

  assign head_cnt  = cnt_q[rd_idx_q];
  // Beats still to come after the current one
  assign head_left = head_cnt - cnt_t'(1);
  assign cnt_len_o = len_t'(head_left);

  assign do_alloc = alloc_req_i & alloc_gnt_o;
  assign do_dec   = cnt_req_i & cnt_gnt_o & cnt_dec_i;
  // Final beat of the head burst frees its slot
  assign do_pop   = do_dec & (cnt_len_o == '0);

  // ----------------------------------------
  // Counter storage
  // ----------------------------------------
  // Allocate and count-down never hit the same slot, the queue would have to be full and empty
  always_ff @(posedge clk_i) begin
    if (do_alloc) begin
      cnt_q[wr_idx_q] <= cnt_t'(alloc_len_i) + cnt_t'(1);
    end
    if (do_dec) begin
      cnt_q[rd_idx_q] <= head_left;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_alloc) begin
        wr_idx_q <= wr_idx_q + cnt_idx_t'(1);
      end
      if (do_pop) begin
        rd_idx_q <= rd_idx_q + cnt_idx_t'(1);
      end
      if (do_alloc && !do_pop) begin
        count_q <= count_q + occ_t'(1);
      end else if (do_pop && !do_alloc) begin
        count_q <= count_q - occ_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/r_last_rebuild.sv */
// R channel stage that forwards read beats and rebuilds last from the head beat counter
`timescale 1ns/10ps
`default_nettype none

module r_last_rebuild (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  // Downstream R
  input  wire logic             mst_r_valid_i,
  input  wire unwrap_pkg::data_t mst_r_data_i,
  input  wire unwrap_pkg::id_t   mst_r_id_i,
  output logic                  mst_r_ready_o,
  // Upstream R
  output logic                  slv_r_valid_o,
  output unwrap_pkg::data_t     slv_r_data_o,
  output unwrap_pkg::id_t       slv_r_id_o,
  output logic                  slv_r_last_o,
  input  wire logic             slv_r_ready_i,
  // Beat counter access
  output logic                  cnt_req_o,
  output logic                  cnt_dec_o,
  input  wire logic             cnt_gnt_i,
  input  wire unwrap_pkg::len_t  cnt_len_i
);

  typedef enum logic {
    R_FEEDTHROUGH,
    R_WAIT
  } r_state_e;

  r_state_e state_q, state_d;
  logic     last_q, last_d;

  always_comb begin
    state_d       = state_q;
    last_d        = last_q;
    cnt_req_o     = 1'b0;
    cnt_dec_o     = 1'b0;
    mst_r_ready_o = 1'b0;
    slv_r_valid_o = 1'b0;
    slv_r_data_o  = mst_r_data_i;
    slv_r_id_o    = mst_r_id_i;
    slv_r_last_o  = 1'b0;

    unique case (state_q)
      R_FEEDTHROUGH: begin
        if (mst_r_valid_i) begin
          cnt_req_o = 1'b1;
          if (cnt_gnt_i) begin
            last_d        = (cnt_len_i == '0);
            slv_r_last_o  = last_d;
            // Counted once, when the beat is first offered
            cnt_dec_o     = 1'b1;
            slv_r_valid_o = 1'b1;
            if (slv_r_ready_i) begin
              mst_r_ready_o = 1'b1;
            end else begin
              state_d = R_WAIT;
            end
          end
        end
      end
      R_WAIT: begin
        // Counter has already moved on, so replay the stored last
        slv_r_last_o  = last_q;
        slv_r_valid_o = mst_r_valid_i;
        if (mst_r_valid_i && slv_r_ready_i) begin
          mst_r_ready_o = 1'b1;
          state_d       = R_FEEDTHROUGH;
        end
      end
      default: begin
        state_d = R_FEEDTHROUGH;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= R_FEEDTHROUGH;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/read_burst_unwrap.sv */
// Top level of the read burst unwrapper; sits between an AXI read master and an in-order memory
`timescale 1ns/10ps
`default_nettype none

module read_burst_unwrap (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  // Upstream AR
  input  wire logic              slv_ar_valid_i,
  input  wire unwrap_pkg::addr_t  slv_ar_addr_i,
  input  wire unwrap_pkg::len_t   slv_ar_len_i,
  input  wire unwrap_pkg::size_t  slv_ar_size_i,
  input  wire unwrap_pkg::burst_t slv_ar_burst_i,
  input  wire unwrap_pkg::id_t    slv_ar_id_i,
  output logic                   slv_ar_ready_o,
  // Upstream R
  output logic                   slv_r_valid_o,
  output unwrap_pkg::data_t      slv_r_data_o,
  output unwrap_pkg::id_t        slv_r_id_o,
  output logic                   slv_r_last_o,
  input  wire logic              slv_r_ready_i,
  // Downstream AR
  output logic                   mst_ar_valid_o,
  output unwrap_pkg::addr_t      mst_ar_addr_o,
  output unwrap_pkg::len_t       mst_ar_len_o,
  output unwrap_pkg::size_t      mst_ar_size_o,
  output unwrap_pkg::burst_t     mst_ar_burst_o,
  output unwrap_pkg::id_t        mst_ar_id_o,
  input  wire logic              mst_ar_ready_i,
  // Downstream R, answered in order
  input  wire logic              mst_r_valid_i,
  input  wire unwrap_pkg::data_t  mst_r_data_i,
  input  wire unwrap_pkg::id_t    mst_r_id_i,
  output logic                   mst_r_ready_o
);
  import unwrap_pkg::*;

  logic alloc_req;
  logic alloc_gnt;
  len_t alloc_len;
  logic cnt_req;
  logic cnt_gnt;
  logic cnt_dec;
  len_t cnt_len;

  // ----------------------------------------
  // AR path
  // ----------------------------------------
  ar_splitter ar_splitter_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ar_valid_i  (slv_ar_valid_i),
    .ar_addr_i   (slv_ar_addr_i),
    .ar_len_i    (slv_ar_len_i),
    .ar_size_i   (slv_ar_size_i),
    .ar_burst_i  (slv_ar_burst_i),
    .ar_id_i     (slv_ar_id_i),
    .ar_ready_o  (slv_ar_ready_o),
    .out_valid_o (mst_ar_valid_o),
    .out_addr_o  (mst_ar_addr_o),
    .out_len_o   (mst_ar_len_o),
    .out_size_o  (mst_ar_size_o),
    .out_burst_o (mst_ar_burst_o),
    .out_id_o    (mst_ar_id_o),
    .out_ready_i (mst_ar_ready_i),
    .alloc_req_o (alloc_req),
    .alloc_len_o (alloc_len),
    .alloc_gnt_i (alloc_gnt)
  );

  beat_count_queue beat_count_queue_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .alloc_req_i (alloc_req),
    .alloc_len_i (alloc_len),
    .alloc_gnt_o (alloc_gnt),
    .cnt_req_i   (cnt_req),
    .cnt_dec_i   (cnt_dec),
    .cnt_gnt_o   (cnt_gnt),
    .cnt_len_o   (cnt_len)
  );

  // ----------------------------------------
  // R path
  // ----------------------------------------
  r_last_rebuild r_last_rebuild_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_id_i    (mst_r_id_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_data_o  (slv_r_data_o),
    .slv_r_id_o    (slv_r_id_o),
    .slv_r_last_o  (slv_r_last_o),
    .slv_r_ready_i (slv_r_ready_i),
    .cnt_req_o     (cnt_req),
    .cnt_dec_o     (cnt_dec),
    .cnt_gnt_i     (cnt_gnt),
    .cnt_len_i     (cnt_len)
  );

endmodule

`default_nettype wire

/* verif/read_burst_unwrap_properties.sv */
// Bound assertions on the unwrapper handshakes and burst encodings, attached to the top level
`timescale 1ns/10ps
`default_nettype none

module read_burst_unwrap_properties (
  input wire logic               clk_i,
  input wire logic               rst_n_i,
  input wire logic               slv_ar_valid_i,
  input wire logic               slv_ar_ready_o,
  input wire unwrap_pkg::addr_t  slv_ar_addr_i,
  input wire unwrap_pkg::len_t   slv_ar_len_i,
  input wire unwrap_pkg::size_t  slv_ar_size_i,
  input wire unwrap_pkg::burst_t slv_ar_burst_i,
  input wire unwrap_pkg::id_t    slv_ar_id_i,
  input wire logic               mst_ar_valid_o,
  input wire logic               mst_ar_ready_i,
  input wire unwrap_pkg::addr_t  mst_ar_addr_o,
  input wire unwrap_pkg::len_t   mst_ar_len_o,
  input wire unwrap_pkg::size_t  mst_ar_size_o,
  input wire unwrap_pkg::burst_t mst_ar_burst_o,
  input wire unwrap_pkg::id_t    mst_ar_id_o,
  input wire logic               slv_r_valid_o,
  input wire logic               slv_r_ready_i,
  input wire unwrap_pkg::data_t  slv_r_data_o,
  input wire unwrap_pkg::id_t    slv_r_id_o,
  input wire logic               slv_r_last_o
);
  import unwrap_pkg::*;

  // ----------------------------------------
  // Valid held with a stable payload
  // ----------------------------------------
  slv_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_ar_valid_i && !slv_ar_ready_o |=> slv_ar_valid_i &&
      $stable({slv_ar_addr_i, slv_ar_len_i, slv_ar_size_i, slv_ar_burst_i, slv_ar_id_i}))
    else $error("upstream AR dropped or changed before ready");

  mst_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o &&
      $stable({mst_ar_addr_o, mst_ar_len_o, mst_ar_size_o, mst_ar_burst_o, mst_ar_id_o}))
    else $error("downstream AR dropped or changed before ready");

  slv_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o &&
      $stable({slv_r_data_o, slv_r_id_o, slv_r_last_o}))
    else $error("upstream R dropped or changed before ready");

  // ----------------------------------------
  // Encodings and reset
  // ----------------------------------------
  mst_ar_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o |-> mst_ar_burst_o != BURST_WRAP)
    else $error("wrap burst reached the downstream AR");

  valid_low_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !mst_ar_valid_o && !slv_r_valid_o)
    else $error("valid output high right after reset");

endmodule

bind read_burst_unwrap read_burst_unwrap_properties props_i (.*);

`default_nettype wire

/* verif/tb_read_burst_unwrap.sv */
// Testbench for the read burst unwrapper with an in-order memory model and random back-pressure
`timescale 1ns/10ps
`default_nettype none

module tb_read_burst_unwrap;
  import unwrap_pkg::*;

  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    id_t    id;
  } ar_req_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    logic  last;
  } exp_beat_t;

  logic   clk_i;
  logic   rst_n_i;
  logic   slv_ar_valid_i;
  addr_t  slv_ar_addr_i;
  len_t   slv_ar_len_i;
  size_t  slv_ar_size_i;
  burst_t slv_ar_burst_i;
  id_t    slv_ar_id_i;
  logic   slv_ar_ready_o;
  logic   slv_r_valid_o;
  data_t  slv_r_data_o;
  id_t    slv_r_id_o;
  logic   slv_r_last_o;
  logic   slv_r_ready_i;
  logic   mst_ar_valid_o;
  addr_t  mst_ar_addr_o;
  len_t   mst_ar_len_o;
  size_t  mst_ar_size_o;
  burst_t mst_ar_burst_o;
  id_t    mst_ar_id_o;
  logic   mst_ar_ready_i;
  logic   mst_r_valid_i;
  data_t  mst_r_data_i;
  id_t    mst_r_id_i;
  logic   mst_r_ready_o;

  ar_req_t     test_q[$];
  exp_beat_t   exp_q[$];
  logic [31:0] rng = 32'ha4384e9a;
  int          error_count = 0;
  int          beats_checked = 0;
  int          down_ar_count = 0;
  int          exp_down_ars = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  read_burst_unwrap dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ----------------------------------------
  // Reference: AXI beat address
  // ----------------------------------------
  function automatic addr_t beat_addr(input addr_t start, input len_t len, input size_t size,
                                      input burst_t burst, input int unsigned beat);
    addr_t bytes;
    addr_t container;
    addr_t lower;
    addr_t addr;
    bytes = addr_t'(1) << size;
    if (burst == BURST_FIXED || beat == 0) begin
      return start;
    end
    addr = (start & ~(bytes - addr_t'(1))) + addr_t'(beat) * bytes;
    if (burst == BURST_WRAP) begin
      container = (addr_t'(len) + addr_t'(1)) * bytes;
      lower     = start & ~(container - addr_t'(1));
      // Past the top of the container, fold back to the boundary
      if (addr >= lower + container) begin
        addr = addr - container;
      end
    end
    return addr;
  endfunction

  task automatic add_test(input addr_t addr, input len_t len, input size_t size,
                          input burst_t burst);
    ar_req_t req;
    req.addr  = addr;
    req.len   = len;
    req.size  = size;
    req.burst = burst;
    req.id    = id_t'(test_q.size());
    test_q.push_back(req);
  endtask

  task automatic build_tests();
    len_t        len;
    logic [31:0] offset;
    addr_t       base;
    // Wrap bursts that start off their boundary
    for (int l = 0; l < 2; l++) begin
      for (int s = 0; s < 3; s++) begin
        len    = (l == 0) ? 8'd3 : 8'd7;
        rng    = xorshift32(rng);
        offset = (rng % 32'(len)) + 32'd1;
        base   = 32'h1000 + 32'h100 * addr_t'(l * 3 + s);
        add_test(base + (addr_t'(offset) << s), len, size_t'(s), BURST_WRAP);
      end
    end
    // Wrap on its boundary
    add_test(32'h3000, 8'd3, 3'd2, BURST_WRAP);
    add_test(32'h3100, 8'd7, 3'd1, BURST_WRAP);
    // Incrementing, fixed and single beat
    add_test(32'h4004, 8'd5, 3'd2, BURST_INCR);
    add_test(32'h5008, 8'd3, 3'd2, BURST_FIXED);
    add_test(32'h6000, 8'd0, 3'd2, BURST_INCR);
    add_test(32'h7010, 8'd15, 3'd2, BURST_INCR);
  endtask

  task automatic send_ar(input ar_req_t req);
    @(negedge clk_i);
    slv_ar_valid_i = 1'b1;
    slv_ar_addr_i  = req.addr;
    slv_ar_len_i   = req.len;
    slv_ar_size_i  = req.size;
    slv_ar_burst_i = req.burst;
    slv_ar_id_i    = req.id;
    @(posedge clk_i);
    while (!slv_ar_ready_o) @(posedge clk_i);
  endtask

  task automatic finish_run();
    $display("Summary: %0d beats checked, %0d errors", beats_checked, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    int planned_beats;
    planned_beats  = 0;
    rst_n_i        = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_ar_size_i  = '0;
    slv_ar_burst_i = BURST_INCR;
    slv_ar_id_i    = '0;
    build_tests();
    foreach (test_q[i]) begin
      planned_beats += int'(test_q[i].len) + 1;
    end
    cycle_limit = 40 * planned_beats + 200;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    // All reads back to back, the queue depth limits what is outstanding
    foreach (test_q[i]) begin
      send_ar(test_q[i]);
    end
    @(negedge clk_i);
    slv_ar_valid_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    if (down_ar_count != exp_down_ars) begin
      $display("** Error at %0t: downstream AR count = %0d, expected %0d",
               $time, down_ar_count, exp_down_ars);
      error_count++;
    end
    finish_run();
  end

  // ----------------------------------------
  // Upstream checker
  // ----------------------------------------
  always @(posedge clk_i) begin : upstream_check
    exp_beat_t exp;
    addr_t     container;
    if (slv_ar_valid_i && slv_ar_ready_o) begin
      for (int unsigned b = 0; b <= 32'(slv_ar_len_i); b++) begin
        exp.data = beat_addr(slv_ar_addr_i, slv_ar_len_i, slv_ar_size_i, slv_ar_burst_i, b);
        exp.id   = slv_ar_id_i;
        exp.last = (b == 32'(slv_ar_len_i));
        exp_q.push_back(exp);
      end
      container = (addr_t'(slv_ar_len_i) + addr_t'(1)) * (addr_t'(1) << slv_ar_size_i);
      if (slv_ar_burst_i == BURST_WRAP && (slv_ar_addr_i % container) != '0) begin
        exp_down_ars += 2;
      end else begin
        exp_down_ars += 1;
      end
    end
    if (slv_r_valid_o && slv_r_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Upstream R beat at %0t arrived with no read outstanding", $time);
        error_count++;
      end else begin
        exp = exp_q.pop_front();
        beats_checked++;
        if (slv_r_data_o != exp.data) begin
          $display("** Error at %0t: slv_r_data_o = 0x%08h, expected 0x%08h",
                   $time, slv_r_data_o, exp.data);
          error_count++;
        end
        if (slv_r_id_o != exp.id) begin
          $display("** Error at %0t: slv_r_id_o = %0d, expected %0d", $time, slv_r_id_o, exp.id);
          error_count++;
        end
        if (slv_r_last_o != exp.last) begin
          $display("** Error at %0t: slv_r_last_o = %0b, expected %0b",
                   $time, slv_r_last_o, exp.last);
          error_count++;
        end
      end
    end
  end

  // ----------------------------------------
  // Memory model and ready drivers
  // ----------------------------------------
  initial begin : memory_model
    ar_req_t     req;
    ar_req_t     mem_q[$];
    int unsigned beat;
    logic        fire;
    beat           = 0;
    fire           = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_data_i   = '0;
    mst_r_id_i     = '0;
    slv_r_ready_i  = 1'b0;
    forever begin
      @(posedge clk_i);
      fire = mst_r_valid_i && mst_r_ready_o;
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        if (mst_ar_burst_o != BURST_INCR && mst_ar_burst_o != BURST_FIXED) begin
          $display("** Error at %0t: mst_ar_burst_o = %0d, expected %0d or %0d",
                   $time, mst_ar_burst_o, BURST_INCR, BURST_FIXED);
          error_count++;
        end
        req.addr  = mst_ar_addr_o;
        req.len   = mst_ar_len_o;
        req.size  = mst_ar_size_o;
        req.burst = mst_ar_burst_o;
        req.id    = mst_ar_id_o;
        mem_q.push_back(req);
        down_ar_count++;
      end
      if (fire) begin
        if (beat == 32'(mem_q[0].len)) begin
          void'(mem_q.pop_front());
          beat = 0;
        end else begin
          beat++;
        end
      end
      @(negedge clk_i);
      rng            = xorshift32(rng);
      mst_ar_ready_i = (rng[4:3] != 2'b00);
      slv_r_ready_i  = (rng[2:1] != 2'b00);
      // A beat not yet taken stays on the bus
      if (!(mst_r_valid_i && !fire)) begin
        if (mem_q.size() != 0 && rng[6:5] != 2'b00) begin
          mst_r_valid_i = 1'b1;
          mst_r_data_i  = beat_addr(mem_q[0].addr, mem_q[0].len, mem_q[0].size,
                                    mem_q[0].burst, beat);
          mst_r_id_i    = mem_q[0].id;
        end else begin
          mst_r_valid_i = 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // Timeout
  // ----------------------------------------
  initial begin : watchdog
    @(posedge clk_i);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, %0d upstream beats never arrived",
             cycle_count, exp_q.size());
    error_count++;
    finish_run();
  end

endmodule

`default_nettype wire

/* project.f */
rtl/unwrap_pkg.sv
rtl/ar_splitter.sv
rtl/beat_count_queue.sv
rtl/r_last_rebuild.sv
rtl/read_burst_unwrap.sv
verif/read_burst_unwrap_properties.sv
verif/tb_read_burst_unwrap.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_read_burst_unwrap
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
